//--- common/fsa_pkg.sv
`default_nettype none

package fsa_pkg;

	// ##################################################
	// frame geometry

	localparam int IMG_W = 16;
	localparam int IMG_H = 12;
	localparam int X_W   = $clog2(IMG_W);
	localparam int Y_W   = $clog2(IMG_H);

	typedef logic [X_W-1:0] img_x_t;   // column index
	typedef logic [Y_W-1:0] img_y_t;   // row index

	// ##################################################
	// streams

	// one mask pixel on the input
	typedef struct packed {
		logic fg;
		logic sof;   // first pixel of the frame
		logic eol;   // last pixel of a row
	} pix_beat_t;

	typedef struct packed {
		img_x_t x;
		logic   val;    // column holds foreground
		img_y_t top;
		img_y_t bot;
		logic   pass;   // 0 for edges and header, 1 for corners
		logic   last;
	} col_prof_t;

	// ##################################################
	// result record

	typedef struct packed {
		img_x_t x;
		img_y_t y;
	} point_t;

	typedef struct packed {
		logic   edge_valid;
		img_x_t edge_x;
		logic   header_valid;
		img_x_t header_x;
		point_t corner_top;
		point_t corner_bot;
	} side_res_t;

	typedef struct packed {
		side_res_t lft;
		side_res_t rt;
	} fsa_res_t;

	typedef enum logic [1:0] {S_FILL, S_PASS0, S_PASS1} scan_state_t;

endpackage

`default_nettype wire

//--- source/column_scanner.sv
`default_nettype none

module column_scanner
	import fsa_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      pix_valid,
	input  pix_beat_t pix,
	output logic      pix_ready,
	output logic      prof_valid,
	output col_prof_t prof
);

	scan_state_t state;
	img_x_t      x_cnt;
	img_y_t      y_cnt;
	img_x_t      rd_x;
	logic        rd_last;

	// per column profile store
	logic   col_val [IMG_W];
	img_y_t col_top [IMG_W];
	img_y_t col_bot [IMG_W];

	logic   pix_acc;
	img_x_t cur_x;
	img_y_t cur_y;
	logic   frame_end;

	assign pix_ready = (state == S_FILL);
	assign pix_acc   = pix_valid && pix_ready;
	assign cur_x     = pix.sof ? '0 : x_cnt;   // sof restarts the raster
	assign cur_y     = pix.sof ? '0 : y_cnt;
	assign frame_end = pix_acc && pix.eol && (cur_y == img_y_t'(IMG_H - 1));

	// ##################################################
	// raster position

	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (pix_acc) begin
			if (pix.eol) begin
				x_cnt <= '0;
				y_cnt <= frame_end ? '0 : cur_y + 1'b1;
			end else begin
				x_cnt <= cur_x + 1'b1;
				y_cnt <= cur_y;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pix_acc) begin
			if (cur_y == '0) begin
				// first row starts a fresh column
				col_val[cur_x] <= pix.fg;
				col_top[cur_x] <= '0;
				col_bot[cur_x] <= '0;
			end else if (pix.fg) begin
				col_val[cur_x] <= 1'b1;
				col_bot[cur_x] <= cur_y;
				if (!col_val[cur_x])
					col_top[cur_x] <= cur_y;   // first hit from above
			end
		end
	end

	// ##################################################
	// two pass readout

	assign rd_last = (rd_x == img_x_t'(IMG_W - 1));

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_FILL;
			rd_x  <= '0;
		end else begin
			case (state)
			S_FILL: begin
				rd_x <= '0;
				if (frame_end)
					state <= S_PASS0;
			end
			S_PASS0: begin
				rd_x <= rd_last ? '0 : rd_x + 1'b1;
				if (rd_last)
					state <= S_PASS1;
			end
			S_PASS1: begin
				rd_x <= rd_last ? '0 : rd_x + 1'b1;
				if (rd_last)
					state <= S_FILL;   // ready for the next frame
			end
			default: state <= S_FILL;
			endcase
		end
	end

	assign prof_valid = (state != S_FILL);

	always_comb begin
		prof.x    = rd_x;
		prof.val  = col_val[rd_x];
		prof.top  = col_top[rd_x];
		prof.bot  = col_bot[rd_x];
		prof.pass = (state == S_PASS1);
		prof.last = rd_last;
	end

	// source must frame rows at the configured width
	a_eol_at_row_end: assert property (@(posedge clk) disable iff (!resetn)
		pix_acc |-> (pix.eol == (cur_x == img_x_t'(IMG_W - 1))));

	// input reopens right after the last pass 1 profile
	a_readout_length: assert property (@(posedge clk) disable iff (!resetn)
		frame_end |-> ##(2 * IMG_W + 1)
			(pix_ready && $past(prof_valid && prof.pass && prof.last)));

endmodule

`default_nettype wire

//--- detect/fsa_detect_header.sv
`default_nettype none

module fsa_detect_header
	import fsa_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      prof_valid,
	input  col_prof_t prof,
	output logic      lft_header_valid,
	output logic      rt_header_valid,
	output img_x_t    lft_header_x,
	output img_x_t    rt_header_x
);

	logic   hdr_found;
	img_y_t min_top;
	logic   scan_en;
	logic   col_first;
	logic   found_now;

	assign scan_en   = prof_valid && !prof.pass;   // header settles in pass 0
	assign col_first = (prof.x == '0);
	assign found_now = hdr_found && !col_first;    // stale frame counts as empty

	always_ff @(posedge clk) begin
		if (!resetn) begin
			hdr_found    <= 1'b0;
			min_top      <= '0;
			lft_header_x <= '0;
			rt_header_x  <= '0;
		end else if (scan_en) begin
			if (col_first) begin
				hdr_found    <= 1'b0;
				min_top      <= '0;
				lft_header_x <= '0;
				rt_header_x  <= '0;
			end
			if (prof.val && (!found_now || prof.top < min_top)) begin
				// new minimum restarts the header range
				hdr_found    <= 1'b1;
				min_top      <= prof.top;
				lft_header_x <= prof.x;
				rt_header_x  <= prof.x;
			end else if (prof.val && prof.top == min_top) begin
				rt_header_x <= prof.x;   // equal top widens to the right
			end
		end
	end

	assign lft_header_valid = hdr_found;
	assign rt_header_valid  = hdr_found;

	a_header_ordered: assert property (@(posedge clk) disable iff (!resetn)
		lft_header_valid |-> (lft_header_x <= rt_header_x));

endmodule

`default_nettype wire

//--- detect/fsa_detect_edge.sv
`default_nettype none

module fsa_detect_edge
	import fsa_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      prof_valid,
	input  col_prof_t prof,
	output fsa_res_t  res,
	output logic      res_done
);

	logic   lft_hdr_valid;
	img_x_t lft_hdr_x;
	logic   rt_hdr_valid;
	img_x_t rt_hdr_x;

	fsa_detect_header header_detector (
		.clk             (clk),
		.resetn          (resetn),
		.prof_valid      (prof_valid),
		.prof            (prof),
		.lft_header_valid(lft_hdr_valid),
		.rt_header_valid (rt_hdr_valid),
		.lft_header_x    (lft_hdr_x),
		.rt_header_x     (rt_hdr_x)
	);

	logic p0_en;
	logic p1_en;
	logic col_first;

	assign p0_en     = prof_valid && !prof.pass;
	assign p1_en     = prof_valid && prof.pass;
	assign col_first = (prof.x == '0);

	// ##################################################
	// pass 0 edges

	logic   lft_edge_valid;
	img_x_t lft_edge_x;
	logic   rt_edge_valid;
	img_x_t rt_edge_x;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_edge_valid <= 1'b0;
			lft_edge_x     <= '0;
			rt_edge_valid  <= 1'b0;
			rt_edge_x      <= '0;
		end else if (p0_en) begin
			if (col_first) begin
				lft_edge_valid <= 1'b0;
				lft_edge_x     <= '0;
				rt_edge_valid  <= 1'b0;
				rt_edge_x      <= '0;
			end
			if (prof.val) begin
				if (!lft_edge_valid || col_first) begin
					lft_edge_valid <= 1'b1;
					lft_edge_x     <= prof.x;
				end
				rt_edge_valid <= 1'b1;
				rt_edge_x     <= prof.x;   // ends on the last valid column
			end
		end
	end

	// ##################################################
	// pass 1 corners

	point_t lft_ctop;
	point_t lft_cbot;
	logic   lft_bot_found;
	point_t rt_ctop;
	point_t rt_cbot;
	logic   rt_bot_found;
	logic   in_lft_span;
	logic   in_rt_span;
	logic   lft_take;
	logic   rt_take;

	assign in_lft_span = lft_hdr_valid && prof.val
		&& (prof.x >= lft_edge_x) && (prof.x <= lft_hdr_x);
	assign in_rt_span  = rt_hdr_valid && prof.val
		&& (prof.x >= rt_hdr_x) && (prof.x <= rt_edge_x);

	// left keeps the first maximum, right keeps the last
	assign lft_take = in_lft_span && (col_first || !lft_bot_found || prof.bot > lft_cbot.y);
	assign rt_take  = in_rt_span && (col_first || !rt_bot_found || prof.bot >= rt_cbot.y);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			lft_ctop      <= '0;
			lft_cbot      <= '0;
			lft_bot_found <= 1'b0;
			rt_ctop       <= '0;
			rt_cbot       <= '0;
			rt_bot_found  <= 1'b0;
		end else if (p1_en) begin
			if (col_first) begin
				lft_ctop      <= '0;
				lft_cbot      <= '0;
				lft_bot_found <= 1'b0;
				rt_ctop       <= '0;
				rt_cbot       <= '0;
				rt_bot_found  <= 1'b0;
			end
			if (lft_edge_valid && prof.x == lft_edge_x)
				lft_ctop <= '{x: prof.x, y: prof.top};
			if (rt_edge_valid && prof.x == rt_edge_x)
				rt_ctop <= '{x: prof.x, y: prof.top};
			if (lft_take) begin
				lft_bot_found <= 1'b1;
				lft_cbot      <= '{x: prof.x, y: prof.bot};
			end
			if (rt_take) begin
				rt_bot_found <= 1'b1;
				rt_cbot      <= '{x: prof.x, y: prof.bot};
			end
		end
	end

	// ##################################################
	// result publish

	logic done_pend;   // last pass 1 column has been folded in

	always_ff @(posedge clk) begin
		if (!resetn) begin
			done_pend <= 1'b0;
			res_done  <= 1'b0;
			res       <= '0;
		end else begin
			done_pend <= p1_en && prof.last;
			res_done  <= done_pend;
			if (done_pend) begin
				res.lft.edge_valid   <= lft_edge_valid;
				res.lft.edge_x       <= lft_edge_x;
				res.lft.header_valid <= lft_hdr_valid;
				res.lft.header_x     <= lft_hdr_x;
				res.lft.corner_top   <= lft_ctop;
				res.lft.corner_bot   <= lft_cbot;
				res.rt.edge_valid    <= rt_edge_valid;
				res.rt.edge_x        <= rt_edge_x;
				res.rt.header_valid  <= rt_hdr_valid;
				res.rt.header_x      <= rt_hdr_x;
				res.rt.corner_top    <= rt_ctop;
				res.rt.corner_bot    <= rt_cbot;
			end
		end
	end

	// scanner must be back in fill once the result lands
	a_done_after_readout: assert property (@(posedge clk) disable iff (!resetn)
		res_done |-> !prof_valid);

endmodule

`default_nettype wire

//--- source/fsa_top.sv
`default_nettype none

module fsa_top
	import fsa_pkg::*;
(
	input  logic      clk,
	input  logic      resetn,
	input  logic      pix_valid,
	input  pix_beat_t pix,
	output logic      pix_ready,
	output fsa_res_t  res,
	output logic      res_done
);

	// profile stream, no back-pressure
	logic      prof_valid;
	col_prof_t prof;

	column_scanner scanner0 (
		.clk       (clk),
		.resetn    (resetn),
		.pix_valid (pix_valid),
		.pix       (pix),
		.pix_ready (pix_ready),
		.prof_valid(prof_valid),
		.prof      (prof)
	);

	fsa_detect_edge detector0 (
		.clk       (clk),
		.resetn    (resetn),
		.prof_valid(prof_valid),
		.prof      (prof),
		.res       (res),
		.res_done  (res_done)
	);

endmodule

`default_nettype wire

//--- verification/tb_fsa_tasks.svh
`ifndef TB_FSA_TASKS_SVH
`define TB_FSA_TASKS_SVH

	bit       mask [IMG_H][IMG_W];   // mask[y][x], 1 is foreground
	fsa_res_t last_res = '0;          // res must hold this until the next res_done
	int       frame_end_edge;         // edge that took the last pixel of a frame
	int       first_acc_edge;
	int       first_wait;             // falling edges the first beat sat behind pix_ready

	// ##################################################
	// compare

	task automatic check_res(input string name, input fsa_res_t got, input fsa_res_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_point(input string name, input point_t got, input point_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_cycle(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	function automatic point_t make_point(input int x, input int y);
		point_t p;
		p.x = img_x_t'(x);
		p.y = img_y_t'(y);
		return p;
	endfunction

	// ##################################################
	// masks and reference outline

	task automatic clear_mask();
		foreach (mask[y, x])
			mask[y][x] = 1'b0;
	endtask

	task automatic set_col(input int x, input int top, input int bot);
		int y;
		for (y = top; y <= bot; y++)
			mask[y][x] = 1'b1;
	endtask

	function automatic fsa_res_t expected_result();
		bit       val [IMG_W];
		int       top [IMG_W];
		int       bot [IMG_W];
		int       x;
		int       y;
		int       le;
		int       re;
		int       lh;
		int       rh;
		int       min_top;
		int       best;
		fsa_res_t e;
		e       = '0;
		le      = -1;
		re      = -1;
		lh      = 0;
		rh      = 0;
		min_top = IMG_H;
		for (x = 0; x < IMG_W; x++) begin
			val[x] = 1'b0;
			top[x] = 0;
			bot[x] = 0;
			for (y = 0; y < IMG_H; y++) begin
				if (mask[y][x]) begin
					if (!val[x])
						top[x] = y;
					bot[x] = y;
					val[x] = 1'b1;
				end
			end
			if (val[x]) begin
				if (le < 0)
					le = x;
				re = x;
				if (top[x] < min_top) begin
					min_top = top[x];
					lh      = x;
				end
				if (top[x] == min_top)
					rh = x;
			end
		end
		if (le < 0)
			return e;   // no foreground, all zero
		e.lft.edge_valid   = 1'b1;
		e.lft.edge_x       = img_x_t'(le);
		e.rt.edge_valid    = 1'b1;
		e.rt.edge_x        = img_x_t'(re);
		e.lft.header_valid = 1'b1;
		e.lft.header_x     = img_x_t'(lh);
		e.rt.header_valid  = 1'b1;
		e.rt.header_x      = img_x_t'(rh);
		e.lft.corner_top   = make_point(le, top[le]);
		e.rt.corner_top    = make_point(re, top[re]);
		best = -1;
		for (x = le; x <= lh; x++) begin
			if (val[x] && bot[x] > best) begin   // first deepest wins
				best             = bot[x];
				e.lft.corner_bot = make_point(x, best);
			end
		end
		best = -1;
		for (x = rh; x <= re; x++) begin
			if (val[x] && bot[x] >= best) begin   // last deepest wins
				best            = bot[x];
				e.rt.corner_bot = make_point(x, best);
			end
		end
		return e;
	endfunction

	// ##################################################
	// pixel driver and result collection

	task automatic send_beat(input pix_beat_t b, output int edge_no, output int waited);
		logic taken;
		taken  = 1'b0;
		waited = 0;
		while (!taken) begin
			@(negedge clk);
			pix_valid = 1'b1;
			pix       = b;
			if (pix_ready) begin
				taken   = 1'b1;
				edge_no = cyc + 1;
			end else begin
				waited++;
			end
		end
	endtask

	task automatic drive_frame(input bit hold_after);
		pix_beat_t b;
		int        x;
		int        y;
		int        e;
		int        w;
		for (y = 0; y < IMG_H; y++) begin
			for (x = 0; x < IMG_W; x++) begin
				if (!(x == 0 && y == 0) && $urandom % 4 == 0) begin
					@(negedge clk);
					pix_valid = 1'b0;   // idle gap
					pix       = '0;
				end
				b.fg  = mask[y][x];
				b.sof = (x == 0 && y == 0);
				b.eol = (x == IMG_W - 1);
				send_beat(b, e, w);
				if (x == 0 && y == 0) begin
					first_acc_edge = e;
					first_wait     = w;
				end
			end
		end
		frame_end_edge = e;
		if (!hold_after) begin
			@(negedge clk);
			pix_valid = 1'b0;
			pix       = '0;
		end
	endtask

	task automatic collect_result(input fsa_res_t exp, input int end_edge);
		do begin
			@(negedge clk);
			if (cyc >= end_edge && cyc < end_edge + 2 * IMG_W)
				check_bit("pix_ready during readout", pix_ready, 1'b0);
			if (!res_done)
				check_res("res before res_done", res, last_res);
		end while (!res_done);
		check_cycle("res_done edge", cyc + 1, end_edge + 2 * IMG_W + 2);
		check_res("res", res, exp);
		last_res = exp;
		@(negedge clk);
		check_bit("res_done after pulse", res_done, 1'b0);
	endtask

	task automatic run_frame();
		drive_frame(1'b0);
		collect_result(expected_result(), frame_end_edge);
	endtask

`endif

//--- verification/tb_fsa.sv
`default_nettype none

module tb_fsa
	import fsa_pkg::*;
();

	localparam int SEED         = 20;
	localparam int FRAME_BUDGET = IMG_W * IMG_H * 3 + 2 * IMG_W + 20;
	localparam int RUN_FRAMES   = 14;   // tests 1 to 4, two frames in test 5, eight random
	localparam int MAX_CYCLES   = RUN_FRAMES * FRAME_BUDGET;

	logic      clk;
	logic      resetn;
	logic      pix_valid;
	pix_beat_t pix;
	logic      pix_ready;
	fsa_res_t  res;
	logic      res_done;

	fsa_top dut0 (
		.clk      (clk),
		.resetn   (resetn),
		.pix_valid(pix_valid),
		.pix      (pix),
		.pix_ready(pix_ready),
		.res      (res),
		.res_done (res_done)
	);

	always #4 clk = ~clk;

	int cyc = 0;   // rising edges seen so far
	always @(posedge clk) cyc <= cyc + 1;

	task automatic stop_with_failure();
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	always @(negedge clk) begin
		if (cyc >= MAX_CYCLES) begin
			$display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
			stop_with_failure();
		end
	end

	`include "tb_fsa_tasks.svh"

	// ##################################################
	// directed tests

	task automatic test_empty();
		int i;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			check_bit("pix_ready", pix_ready, 1'b1);   // idle after reset
			check_bit("res_done", res_done, 1'b0);
			check_res("res", res, '0);
		end
		clear_mask();
		run_frame();
		check_bit("res.lft.edge_valid", res.lft.edge_valid, 1'b0);
		check_bit("res.rt.edge_valid", res.rt.edge_valid, 1'b0);
		check_bit("res.lft.header_valid", res.lft.header_valid, 1'b0);
		check_bit("res.rt.header_valid", res.rt.header_valid, 1'b0);
	endtask

	task automatic test_rectangle();
		int x;
		clear_mask();
		for (x = 3; x <= 11; x++)
			set_col(x, 2, 8);
		run_frame();
		check_point("res.lft.corner_top", res.lft.corner_top, make_point(3, 2));
		check_point("res.lft.corner_bot", res.lft.corner_bot, make_point(3, 8));
		check_point("res.rt.corner_top", res.rt.corner_top, make_point(11, 2));
		check_point("res.rt.corner_bot", res.rt.corner_bot, make_point(11, 8));
	endtask

	task automatic test_trapezoid();
		int bots [12] = '{8, 9, 9, 8, 7, 11, 11, 7, 8, 10, 10, 9};
		int x;
		int t;
		clear_mask();
		// flat top on 6..9, sides fall away, deepest columns sit under the header
		for (x = 2; x <= 13; x++) begin
			if (x < 6)
				t = 8 - x;
			else if (x > 9)
				t = x - 7;
			else
				t = 2;
			set_col(x, t, bots[x - 2]);
		end
		run_frame();
	endtask

	task automatic test_peak();
		int x;
		clear_mask();
		for (x = 2; x <= 12; x++)
			set_col(x, (x < 7) ? 8 - x : x - 6, 10);   // apex on column 7
		run_frame();
	endtask

	task automatic test_back_to_back();
		fsa_res_t exp_a;
		int       end_a;
		int       x;
		clear_mask();
		for (x = 4; x <= 9; x++)
			set_col(x, 3, 7);
		drive_frame(1'b1);
		exp_a = expected_result();
		end_a = frame_end_edge;
		clear_mask();
		for (x = 0; x < IMG_W; x++)
			set_col(x, x % 4 + 1, 11 - x % 3);
		fork
			drive_frame(1'b0);   // first beat waits out the readout
			collect_result(exp_a, end_a);
		join
		check_cycle("first beat wait", first_wait, 2 * IMG_W);
		check_cycle("first beat edge", first_acc_edge, end_a + 2 * IMG_W + 1);
		collect_result(expected_result(), frame_end_edge);
	endtask

	task automatic test_random();
		int n;
		int x;
		int x0;
		int x1;
		int t;
		for (n = 0; n < 8; n++) begin
			clear_mask();
			x0 = int'($urandom % IMG_W);
			x1 = x0 + int'($urandom % (IMG_W - x0));
			for (x = x0; x <= x1; x++) begin
				if ($urandom % 5 != 0) begin
					t = int'($urandom % IMG_H);
					set_col(x, t, t + int'($urandom % (IMG_H - t)));
				end
			end
			run_frame();
		end
	endtask

	initial begin
		void'($urandom(SEED));
		clk       = 1'b0;
		resetn    = 1'b0;
		pix_valid = 1'b0;
		pix       = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;

		test_empty();
		test_rectangle();
		test_trapezoid();
		test_peak();
		test_back_to_back();
		test_random();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+verification
common/fsa_pkg.sv
source/column_scanner.sv
detect/fsa_detect_header.sv
detect/fsa_detect_edge.sv
source/fsa_top.sv
verification/tb_fsa.sv

//--- Makefile
# Verilator build and run for the outline measurement subsystem

VERILATOR ?= verilator
TOP       ?= tb_fsa
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := TESTS FAILED
PASS_MSG := TESTS PASSED
SOURCES  := $(shell grep -v '^+' $(FILELIST)) verification/tb_fsa_tasks.svh
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
